// ==== sources.f ====
logic/dla_pkg.sv
logic/dla_config_regs.sv
logic/dla_walker.sv
logic/dla_particle_check.sv
logic/dla_vram.sv
logic/dla_top.sv
verification/dla_checker.sv
verification/dla_tb.sv

// ==== Bender.yml ====
package:
  name: dla

sources:
  - logic/dla_pkg.sv
  - logic/dla_config_regs.sv
  - logic/dla_walker.sv
  - logic/dla_particle_check.sv
  - logic/dla_vram.sv
  - logic/dla_top.sv
  - target: simulation
    files:
      - verification/dla_checker.sv
      - verification/dla_tb.sv

// ==== verification/dla_tb.sv ====
// DLA testbench with clock, xorshift, reference model, host stimulus and comparison
`timescale 1ns/1ps

module dla_tb;
    import dla_pkg::*;

    logic              clk;
    logic              rst;
    logic              cfg_write;
    logic              cfg_read;
    logic [1:0]        cfg_addr;
    logic [CFG_W-1:0]  cfg_wdata;
    logic [CFG_W-1:0]  cfg_rdata;
    logic              cfg_rvalid;
    logic [ADDR_W-1:0] pix_address;
    logic              pix_read;
    logic              pix_waitrequest;
    logic [PIX_W-1:0]  pix_readdata;
    logic              pix_readdatavalid;

    logic [PIX_W-1:0]  model_img [GRID_W*GRID_H];
    logic [PIX_W-1:0]  pix_exp_q [$];   // expected host read data in issue order
    logic [CFG_W-1:0]  cfg_exp_q [$];
    logic [CFG_W-1:0]  cfg_msk_q [$];   // mask 0 marks a status poll
    logic [ADDR_W-1:0] addr_q [$];
    logic [31:0]       rnd;
    logic [CFG_W-1:0]  rdata;
    string             test_name;
    int                model_cnt;

    dla_top dut_i (.*);

    bind dla_particle_check dla_checker chk_eng_i (
        .clk(clk), .rst(rst), .address(eng_address), .read(eng_read),
        .waitrequest(eng_waitrequest), .readdatavalid(eng_readdatavalid),
        .check_x(check_x), .check_y(check_y), .check_start(check_start),
        .check_done(check_done), .write(1'b0), .clearing(1'b0)
    );

    bind dla_vram dla_checker chk_pix_i (
        .clk(clk), .rst(rst), .address(pix_address), .read(pix_read),
        .waitrequest(pix_waitrequest), .readdatavalid(pix_readdatavalid),
        .check_x('0), .check_y('0), .check_start(1'b0), .check_done(1'b0),
        .write(eng_write), .clearing(clearing)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] r;
        r = s ^ (s << 13);
        r = r ^ (r >> 17);
        return r ^ (r << 5);
    endfunction

    // 3x3 neighbourhood of an interior position including the centre
    function automatic logic near_filled(input int x, input int y);
        for (int dy = -1; dy <= 1; dy++)
            for (int dx = -1; dx <= 1; dx++)
                if (model_img[(y + dy) * GRID_W + x + dx] == PIXEL_FILLED)
                    return 1'b1;
        return 1'b0;
    endfunction

    // ------------------------------------------------------------------------
    // reference model that grows the cluster in model_img and returns the count
    // ------------------------------------------------------------------------
    function automatic int run_model(input logic [31:0] seed, input int target);
        logic [31:0] s;
        int          x;
        int          y;
        int          cnt;
        int          steps;
        logic        spawn;
        s     = seed;
        x     = GRID_W / 2;
        y     = GRID_H / 2;
        model_img[y * GRID_W + x] = PIXEL_FILLED;   // seed pixel
        cnt   = 1;
        steps = 0;
        spawn = 1'b1;
        while (cnt < target && steps < 10_000_000) begin
            steps++;
            if (spawn) begin
                s     = xorshift32(s);
                x     = s[4:0];
                y     = s[9:5];
                spawn = 1'b0;
            end
            if (x == 0 || x == GRID_W - 1 || y == 0 || y == GRID_H - 1) begin
                spawn = 1'b1;                       // lost at the edge
            end else if (near_filled(x, y)) begin
                model_img[y * GRID_W + x] = PIXEL_FILLED;
                cnt++;
                spawn = 1'b1;
            end else begin
                s = xorshift32(s);
                case (s[1:0])
                    2'd0: x++;
                    2'd1: x--;
                    2'd2: y++;
                    2'd3: y--;
                endcase
            end
        end
        return cnt;
    endfunction

    task automatic fail_stop(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic write_reg(input logic [1:0] addr, input logic [CFG_W-1:0] data);
        cfg_write <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge clk);
        cfg_write <= 1'b0;
    endtask

    // read data comes back exactly one cycle after cfg_read is sampled
    task automatic read_reg(input logic [1:0] addr, input logic [CFG_W-1:0] exp,
                            input logic [CFG_W-1:0] mask);
        cfg_exp_q.push_back(exp & mask);
        cfg_msk_q.push_back(mask);
        cfg_read <= 1'b1;
        cfg_addr <= addr;
        @(posedge clk);
        cfg_read <= 1'b0;
        @(posedge clk);
        assert (cfg_rvalid) else fail_stop("cfg_rvalid did not follow a register read");
        rdata = cfg_rdata;
    endtask

    task automatic wait_status(input logic [CFG_W-1:0] mask, input logic [CFG_W-1:0] val,
                               input int max_polls, input string what);
        int polls;
        polls = 0;
        do begin
            read_reg(REG_STATUS, '0, '0);
            polls++;
            assert (polls <= max_polls) else fail_stop({"timeout waiting for ", what});
        end while ((rdata & mask) != val);
    endtask

    task automatic drain();
        int guard;
        guard = 0;
        while (pix_exp_q.size() > 0) begin
            @(posedge clk);
            guard++;
            assert (guard < 20) else fail_stop("host read data did not come back");
        end
    endtask

    // reads every address in addr_q one at a time or one per accepted cycle
    task automatic read_pixels(input bit pipelined);
        int guard;
        guard = 0;
        while (addr_q.size() > 0) begin
            pix_read    <= 1'b1;
            pix_address <= addr_q[0];
            @(posedge clk);
            guard++;
            assert (guard < 100_000) else fail_stop("host pixel reads were not accepted");
            if (!pix_waitrequest) begin
                pix_exp_q.push_back(model_img[addr_q.pop_front()]);
                if (!pipelined) begin
                    pix_read <= 1'b0;
                    drain();
                end
            end
        end
        pix_read <= 1'b0;
        drain();
    endtask

    task automatic run_and_check(input int target);
        test_name = $sformatf("run with seed %h", rnd);
        model_cnt = run_model(rnd, target);
        write_reg(REG_SEED, rnd);
        write_reg(REG_TARGET, target);
        write_reg(REG_CTRL, 32'h1);
        wait_status(32'h1, 32'h1, 20, "busy after start");
        read_reg(REG_STATUS, 32'h1, 32'h3);     // running with done cleared
        write_reg(REG_CTRL, 32'h1);             // ignored while busy
        wait_status(32'h2, 32'h2, 2_000_000, "done at the end of the run");
        read_reg(REG_STATUS, {6'd0, 10'(model_cnt), 16'h0002}, 32'h03ff_0007);
        test_name = $sformatf("image after seed %h", rnd);
        for (int i = 0; i < GRID_W * GRID_H; i++)
            addr_q.push_back(ADDR_W'(i));
        read_pixels(1'b0);
    endtask

    // compares every returned register and pixel word
    always @(posedge clk) begin : compare_returns
        logic [CFG_W-1:0] ce;
        logic [CFG_W-1:0] cm;
        logic [PIX_W-1:0] pe;
        if (cfg_rvalid) begin
            assert (cfg_exp_q.size() > 0) else fail_stop("register read data without a read");
            ce = cfg_exp_q.pop_front();
            cm = cfg_msk_q.pop_front();
            assert ((cfg_rdata & cm) == ce) else fail_stop($sformatf(
                "Fail %s: expected %h, actual %h", test_name, ce, cfg_rdata & cm));
        end
        if (pix_readdatavalid) begin
            assert (pix_exp_q.size() > 0) else fail_stop("host read data without a read");
            pe = pix_exp_q.pop_front();
            assert (pix_readdata == pe) else fail_stop($sformatf(
                "Fail %s: expected %h, actual %h", test_name, pe, pix_readdata));
        end
        assert (dut_i.check_i.chk_eng_i.fail_cnt == 0 && dut_i.vram_i.chk_pix_i.fail_cnt == 0)
            else fail_stop("a bound handshake assertion failed");
    end

    initial begin
        rst         = 1'b1;
        cfg_write   = 1'b0;
        cfg_read    = 1'b0;
        cfg_addr    = '0;
        cfg_wdata   = '0;
        pix_address = '0;
        pix_read    = 1'b0;
        rnd         = 32'he806_130a;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        test_name = "register readback";
        read_reg(REG_STATUS, 32'h4, 32'h7);     // sweep running and walker idle
        write_reg(REG_SEED, '0);
        read_reg(REG_SEED, 32'd1, '1);
        write_reg(REG_SEED, 32'h1234_5678);
        read_reg(REG_SEED, 32'h1234_5678, '1);
        write_reg(REG_TARGET, 32'd40);
        read_reg(REG_TARGET, 32'd40, '1);
        wait_status(32'h4, 32'h0, 1000, "end of the clear sweep");
        read_reg(REG_STATUS, 32'h0, '1);

        test_name = "clear sweep";
        for (int i = 0; i < GRID_W * GRID_H; i++)
            model_img[i] = PIXEL_EMPTY;
        repeat (32) begin
            rnd = xorshift32(rnd);
            addr_q.push_back(rnd[ADDR_W-1:0]);
        end
        read_pixels(1'b0);

        rnd = xorshift32(rnd);
        run_and_check(40);

        test_name = "pipelined host reads";
        repeat (64) begin
            rnd = xorshift32(rnd);
            // central 8x8 block where the cluster grows
            addr_q.push_back(ADDR_W'((12 + rnd[5:3]) * GRID_W + 12 + rnd[2:0]));
        end
        read_pixels(1'b1);

        rnd = xorshift32(rnd);
        run_and_check(25);                      // grows on the first image

        $display("All checks passed");
        $finish;
    end

endmodule

// ==== verification/dla_checker.sv ====
// bound checker: read latency, held read requests, held check coordinates, no write in sweep
`timescale 1ns/1ps

module dla_checker (
    input logic                       clk,
    input logic                       rst,
    input logic [dla_pkg::ADDR_W-1:0] address,
    input logic                       read,
    input logic                       waitrequest,
    input logic                       readdatavalid,
    input logic [dla_pkg::X_W-1:0]    check_x,
    input logic [dla_pkg::Y_W-1:0]    check_y,
    input logic                       check_start,
    input logic                       check_done,
    input logic                       write,
    input logic                       clearing
);
    import dla_pkg::*;

    int   fail_cnt = 0;
    logic in_check;     // between check_start and check_done

    always_ff @(posedge clk) begin
        if (rst)
            in_check <= 1'b0;
        else if (check_done)
            in_check <= 1'b0;
        else if (check_start)
            in_check <= 1'b1;
    end

    a_latency: assert property (@(posedge clk) disable iff (rst)
            (read && !waitrequest) |-> ##VRAM_READ_LATENCY readdatavalid)
        else begin
            $error("read data did not return after the fixed read latency");
            fail_cnt++;
        end

    a_no_extra_valid: assert property (@(posedge clk) disable iff (rst)
            readdatavalid |-> $past(read && !waitrequest, VRAM_READ_LATENCY))
        else begin
            $error("readdatavalid without a matching accepted read");
            fail_cnt++;
        end

    // a stalled read keeps its request and address
    a_read_held: assert property (@(posedge clk) disable iff (rst)
            (read && waitrequest) |=> (read && $stable(address)))
        else begin
            $error("read request or address changed under waitrequest");
            fail_cnt++;
        end

    a_coord_held: assert property (@(posedge clk) disable iff (rst)
            in_check |-> ($stable(check_x) && $stable(check_y)))
        else begin
            $error("particle coordinates changed during a check");
            fail_cnt++;
        end

    a_no_write_clear: assert property (@(posedge clk) disable iff (rst)
            clearing |-> !write)
        else begin
            $error("write strobe during the clear sweep");
            fail_cnt++;
        end

endmodule

// ==== logic/dla_top.sv ====
// top level: register block, walker, particle check and frame buffer
`timescale 1ns/1ps

module dla_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cfg_write,
    input  logic                       cfg_read,
    input  logic [1:0]                 cfg_addr,
    input  logic [dla_pkg::CFG_W-1:0]  cfg_wdata,
    output logic [dla_pkg::CFG_W-1:0]  cfg_rdata,
    output logic                       cfg_rvalid,
    input  logic [dla_pkg::ADDR_W-1:0] pix_address,
    input  logic                       pix_read,
    output logic                       pix_waitrequest,
    output logic [dla_pkg::PIX_W-1:0]  pix_readdata,
    output logic                       pix_readdatavalid
);
    import dla_pkg::*;

    // register block to walker
    logic             start;
    logic [CFG_W-1:0] seed;
    logic [CNT_W-1:0] target;
    logic             busy;
    logic             finished;
    logic [CNT_W-1:0] count;
    logic             clearing;

    // walker to particle check
    logic [X_W-1:0]   check_x;
    logic [Y_W-1:0]   check_y;
    logic             check_start;
    logic             check_done;
    logic             hit_boundary;
    logic             hit_neighbor;

    // engine side of the frame buffer
    logic [ADDR_W-1:0] eng_address;
    logic              eng_read;
    logic              eng_waitrequest;
    logic [PIX_W-1:0]  eng_readdata;
    logic              eng_readdatavalid;
    logic              eng_write;
    logic [ADDR_W-1:0] eng_waddress;
    logic [PIX_W-1:0]  eng_wdata;

    dla_config_regs regs_i (.*);

    dla_walker walker_i (.*);

    dla_particle_check check_i (.*);

    dla_vram vram_i (.*);

endmodule

// ==== logic/dla_vram.sv ====
// frame buffer: clear sweep after reset, fixed priority arbitration, fixed latency reads
`timescale 1ns/1ps

module dla_vram (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [dla_pkg::ADDR_W-1:0] eng_address,
    input  logic                       eng_read,
    output logic                       eng_waitrequest,
    output logic [dla_pkg::PIX_W-1:0]  eng_readdata,
    output logic                       eng_readdatavalid,
    input  logic                       eng_write,
    input  logic [dla_pkg::ADDR_W-1:0] eng_waddress,
    input  logic [dla_pkg::PIX_W-1:0]  eng_wdata,
    input  logic [dla_pkg::ADDR_W-1:0] pix_address,
    input  logic                       pix_read,
    output logic                       pix_waitrequest,
    output logic [dla_pkg::PIX_W-1:0]  pix_readdata,
    output logic                       pix_readdatavalid,
    output logic                       clearing
);
    import dla_pkg::*;

    localparam int L = VRAM_READ_LATENCY;

    logic [PIX_W-1:0]  mem [GRID_W*GRID_H];
    logic [ADDR_W-1:0] clr_addr;
    logic              eng_grant;
    logic              pix_grant;
    logic [ADDR_W-1:0] rd_addr;
    logic [L-1:0]      vld_q;
    logic [L-1:0]      port_q;      // 1 marks a host read
    logic [PIX_W-1:0]  data_q [L];

    // priority: clear sweep, write, engine read, host read
    assign eng_waitrequest = clearing || eng_write;
    assign pix_waitrequest = clearing || eng_write || eng_read;
    assign eng_grant       = eng_read && !eng_waitrequest;
    assign pix_grant       = pix_read && !pix_waitrequest;
    assign rd_addr         = eng_read ? eng_address : pix_address;

    // ------------------------------------------------------------------------
    // clear sweep, one address per cycle
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            clearing <= 1'b1;
            clr_addr <= '0;
        end else if (clearing) begin
            clr_addr <= clr_addr + ADDR_W'(1);
            if (clr_addr == ADDR_W'(GRID_W*GRID_H - 1))
                clearing <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= eng_grant || pix_grant;
            for (int i = 1; i < L; i++)
                vld_q[i] <= vld_q[i-1];
        end
    end

    // memory array and read data pipeline
    always_ff @(posedge clk) begin
        if (clearing)
            mem[clr_addr] <= PIXEL_EMPTY;
        else if (eng_write)
            mem[eng_waddress] <= eng_wdata;
        data_q[0] <= mem[rd_addr];
        port_q[0] <= pix_grant;
        for (int i = 1; i < L; i++) begin
            data_q[i] <= data_q[i-1];
            port_q[i] <= port_q[i-1];
        end
    end

    assign eng_readdatavalid = vld_q[L-1] && !port_q[L-1];
    assign pix_readdatavalid = vld_q[L-1] && port_q[L-1];
    assign eng_readdata      = data_q[L-1];
    assign pix_readdata      = data_q[L-1];

endmodule

// ==== logic/dla_particle_check.sv ====
// grid boundary test and nine pixel neighbour search over the engine read port
`timescale 1ns/1ps

module dla_particle_check (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [dla_pkg::X_W-1:0]    check_x,
    input  logic [dla_pkg::Y_W-1:0]    check_y,
    input  logic                       check_start,
    output logic                       check_done,
    output logic                       hit_boundary,
    output logic                       hit_neighbor,
    output logic [dla_pkg::ADDR_W-1:0] eng_address,
    output logic                       eng_read,
    input  logic [dla_pkg::PIX_W-1:0]  eng_readdata,
    input  logic                       eng_waitrequest,
    input  logic                       eng_readdatavalid
);
    import dla_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,     // wait for check_start
        S_REQ,      // hold the read until accepted
        S_READ,     // wait for readdatavalid
        S_CHECK     // compare the returned word
    } state_t;

    state_t           state;
    logic [8:0]       pos_oh;       // one-hot over the 3x3 neighbourhood
    logic [PIX_W-1:0] rdata_q;
    logic             col_l;        // column x-1
    logic             col_r;        // column x+1
    logic             row_u;        // row y-1
    logic             row_d;        // row y+1
    logic [X_W-1:0]   nx;
    logic [Y_W-1:0]   ny;

    assign hit_boundary = (check_x == '0) || (check_x == X_W'(GRID_W - 1))
                       || (check_y == '0) || (check_y == Y_W'(GRID_H - 1));
    assign hit_neighbor = (rdata_q == PIXEL_FILLED);

    // ------------------------------------------------------------------------
    // neighbour positions in row major order from (x-1, y-1) to (x+1, y+1)
    // ------------------------------------------------------------------------
    assign col_l = pos_oh[0] | pos_oh[3] | pos_oh[6];
    assign col_r = pos_oh[2] | pos_oh[5] | pos_oh[8];
    assign row_u = pos_oh[0] | pos_oh[1] | pos_oh[2];
    assign row_d = pos_oh[6] | pos_oh[7] | pos_oh[8];

    // only interior positions get here so the edges never wrap
    always_comb begin
        nx = check_x;
        ny = check_y;
        if (col_l) nx = check_x - X_W'(1);
        if (col_r) nx = check_x + X_W'(1);
        if (row_u) ny = check_y - Y_W'(1);
        if (row_d) ny = check_y + Y_W'(1);
    end

    assign eng_address = {ny, nx};      // grid width is a power of two
    assign eng_read    = (state == S_REQ);
    assign check_done  = ((state == S_IDLE) && check_start && hit_boundary)
                      || ((state == S_CHECK) && (hit_neighbor || pos_oh[8]));

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= S_IDLE;
            pos_oh <= 9'b1;
        end else begin
            case (state)
                S_IDLE: if (check_start && !hit_boundary) begin
                    state  <= S_REQ;
                    pos_oh <= 9'b1;             // every check starts at the corner
                end
                S_REQ:  if (!eng_waitrequest) state <= S_READ;
                S_READ: if (eng_readdatavalid) state <= S_CHECK;
                S_CHECK: begin
                    pos_oh <= {pos_oh[7:0], pos_oh[8]};
                    state  <= (hit_neighbor || pos_oh[8]) ? S_IDLE : S_REQ;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (eng_readdatavalid)
            rdata_q <= eng_readdata;
    end

endmodule

// ==== logic/dla_walker.sv ====
// random walk engine: seed pixel, spawn, step and stick of particles, particle count
`timescale 1ns/1ps

module dla_walker (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  logic [dla_pkg::CFG_W-1:0]  seed,
    input  logic [dla_pkg::CNT_W-1:0]  target,
    output logic [dla_pkg::X_W-1:0]    check_x,
    output logic [dla_pkg::Y_W-1:0]    check_y,
    output logic                       check_start,
    input  logic                       check_done,
    input  logic                       hit_boundary,
    input  logic                       hit_neighbor,
    output logic                       eng_write,
    output logic [dla_pkg::ADDR_W-1:0] eng_waddress,
    output logic [dla_pkg::PIX_W-1:0]  eng_wdata,
    output logic                       busy,
    output logic                       finished,
    output logic [dla_pkg::CNT_W-1:0]  count
);
    import dla_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE, S_SEED, S_SPAWN, S_CHECK, S_WAIT, S_STICK
    } state_t;

    state_t           state;
    logic [31:0]      rng;
    logic [31:0]      rng_nxt;
    logic [CNT_W-1:0] count_inc;
    logic             chk_end;
    logic             last;

    // xorshift32, one draw per spawn or step
    always_comb begin
        rng_nxt = rng ^ (rng << 13);
        rng_nxt = rng_nxt ^ (rng_nxt >> 17);
        rng_nxt = rng_nxt ^ (rng_nxt << 5);
    end

    assign count_inc    = count + CNT_W'(1);
    assign chk_end      = (state == S_CHECK || state == S_WAIT) && check_done;
    assign last         = (state == S_STICK) ? (count_inc >= target) : (target <= CNT_W'(1));

    assign check_start  = (state == S_CHECK);
    assign eng_write    = (state == S_SEED) || (state == S_STICK);
    assign eng_waddress = {check_y, check_x};
    assign eng_wdata    = PIXEL_FILLED;
    assign finished     = ((state == S_SEED) || (state == S_STICK)) && last;

    // ------------------------------------------------------------------------
    // control FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            busy  <= 1'b0;
            count <= '0;
        end else begin
            case (state)
                S_IDLE: if (start) begin
                    state <= S_SEED;
                    busy  <= 1'b1;
                end
                S_SEED: begin
                    count <= CNT_W'(1);             // seed pixel is particle one
                    state <= last ? S_IDLE : S_SPAWN;
                    busy  <= !last;
                end
                S_SPAWN: state <= S_CHECK;
                S_CHECK, S_WAIT: begin
                    if (!check_done)
                        state <= S_WAIT;
                    else if (hit_boundary)
                        state <= S_SPAWN;           // discard, try a new particle
                    else if (hit_neighbor)
                        state <= S_STICK;
                    else
                        state <= S_CHECK;           // stepped, check again
                end
                S_STICK: begin
                    count <= count_inc;
                    state <= last ? S_IDLE : S_SPAWN;
                    busy  <= !last;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // position and random state, held while a check is running
    always_ff @(posedge clk) begin
        if (state == S_IDLE && start) begin
            rng     <= seed;
            check_x <= X_W'(GRID_W / 2);
            check_y <= Y_W'(GRID_H / 2);
        end else if (state == S_SPAWN) begin
            rng     <= rng_nxt;
            check_x <= rng_nxt[4:0];
            check_y <= rng_nxt[9:5];
        end else if (chk_end && !hit_boundary && !hit_neighbor) begin
            rng <= rng_nxt;
            case (rng_nxt[1:0])
                2'd0: check_x <= check_x + X_W'(1);
                2'd1: check_x <= check_x - X_W'(1);
                2'd2: check_y <= check_y + Y_W'(1);
                2'd3: check_y <= check_y - Y_W'(1);
            endcase
        end
    end

endmodule

// ==== logic/dla_config_regs.sv ====
// host register block: seed and target registers, start pulse, status readback
`timescale 1ns/1ps

module dla_config_regs (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cfg_write,
    input  logic                      cfg_read,
    input  logic [1:0]                cfg_addr,
    input  logic [dla_pkg::CFG_W-1:0] cfg_wdata,
    output logic [dla_pkg::CFG_W-1:0] cfg_rdata,
    output logic                      cfg_rvalid,
    output logic                      start,
    output logic [dla_pkg::CFG_W-1:0] seed,
    output logic [dla_pkg::CNT_W-1:0] target,
    input  logic                      busy,
    input  logic                      finished,
    input  logic [dla_pkg::CNT_W-1:0] count,
    input  logic                      clearing
);
    import dla_pkg::*;

    logic             done;
    logic             start_req;
    logic [CFG_W-1:0] status;

    // a start in flight counts as busy until the walker raises busy
    assign start_req = cfg_write && (cfg_addr == REG_CTRL) && cfg_wdata[0]
                       && !busy && !clearing && !start;

    always_comb begin
        status        = '0;
        status[0]     = busy;
        status[1]     = done;
        status[2]     = clearing;
        status[25:16] = count;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            start      <= 1'b0;
            done       <= 1'b0;
            seed       <= CFG_W'(1);
            target     <= '0;
            cfg_rvalid <= 1'b0;
        end else begin
            start      <= start_req;
            cfg_rvalid <= cfg_read;
            if (start)
                done <= 1'b0;
            else if (finished)
                done <= 1'b1;              // sticky until the next run
            if (cfg_write && cfg_addr == REG_SEED)
                seed <= (cfg_wdata == '0) ? CFG_W'(1) : cfg_wdata;   // xorshift dies at 0
            if (cfg_write && cfg_addr == REG_TARGET)
                target <= cfg_wdata[CNT_W-1:0];
        end
    end

    // read data is registered, valid one cycle after cfg_read
    always_ff @(posedge clk) begin
        case (cfg_addr)
            REG_SEED:   cfg_rdata <= seed;
            REG_TARGET: cfg_rdata <= CFG_W'(target);
            REG_STATUS: cfg_rdata <= status;
            default:    cfg_rdata <= '0;
        endcase
    end

endmodule

// ==== logic/dla_pkg.sv ====
// package: grid geometry, pixel values, register map, memory read latency
package dla_pkg;

    // ------------------------------------------------------------------------
    // grid geometry
    // ------------------------------------------------------------------------
    localparam int GRID_W = 32;
    localparam int GRID_H = 32;
    localparam int X_W    = 5;
    localparam int Y_W    = 5;
    localparam int ADDR_W = 10;     // address = y * GRID_W + x, i.e. {y, x}

    // ------------------------------------------------------------------------
    // pixel words
    // ------------------------------------------------------------------------
    localparam int PIX_W = 16;
    localparam logic [PIX_W-1:0] PIXEL_EMPTY  = '1;    // background
    localparam logic [PIX_W-1:0] PIXEL_FILLED = '0;    // part of the cluster

    // cycles from an accepted read to readdatavalid
    localparam int VRAM_READ_LATENCY = 2;

    // particle counter
    localparam int CNT_W = 10;

    // ------------------------------------------------------------------------
    // host register map
    // ------------------------------------------------------------------------
    localparam int CFG_W = 32;
    localparam logic [1:0] REG_CTRL   = 2'd0;   // bit 0 starts a run
    localparam logic [1:0] REG_SEED   = 2'd1;
    localparam logic [1:0] REG_TARGET = 2'd2;
    localparam logic [1:0] REG_STATUS = 2'd3;

endpackage
